// ==== verilog/mult_pkg.sv ====
package mult_pkg;

	// Operand width used when the top level does not override P_WIDTH.
	localparam int DEFAULT_WIDTH = 8;

	// Controller states of the shift-and-add sequence.
	// IDLE waits for a start strobe while ready is high.
	// INIT requests the operand load and the partial product clear.
	// ADD_SHIFT issues one step per cycle until the exit condition holds.
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		INIT      = 2'd1,
		ADD_SHIFT = 2'd2
	} state_e;

	// Strobes from the controller to both datapath modules.
	// The load strobe samples both operands into their registers.
	// The clean strobe zeroes the partial product and its shift count.
	// The step strobe performs one add and shift.
	// The show strobe copies the aligned product into the result register.
	typedef struct packed {
		logic load;
		logic clean;
		logic step;
		logic show;
	} ctrl_t;

	// Strobe values held by the controller while in reset.
	// Clean stays high so the accumulator is cleared during reset.
	localparam ctrl_t CTRL_RESET = '{
		load:  1'b0,
		clean: 1'b1,
		step:  1'b0,
		show:  1'b0
	};

	// Strobe values with nothing requested.
	localparam ctrl_t CTRL_IDLE = '{
		load:  1'b0,
		clean: 1'b0,
		step:  1'b0,
		show:  1'b0
	};

endpackage

// ==== verilog/mult_control.sv ====
`timescale 1ns/1ps

module mult_control
	import mult_pkg::*;
#(
	parameter int P_WIDTH = DEFAULT_WIDTH
) (
	input  logic  i_clk,
	input  logic  i_rst,
	input  logic  i_start,
	input  logic  i_done,
	output ctrl_t o_ctrl,
	output logic  o_ready
);

	// The step counter has to reach P_WIDTH itself.
	localparam int P_CNTW = $clog2(P_WIDTH + 1);

	typedef logic [P_CNTW-1:0] cnt_t;

	localparam cnt_t LP_MAX_CNT = cnt_t'(P_WIDTH);

	state_e r_state;
	ctrl_t  r_ctrl;
	logic   r_ready;
	cnt_t   r_count;
	logic   w_accept;
	logic   w_exit;

	// A start strobe counts only while the ready level is up.
	assign w_accept = i_start && r_ready;

	// At least one step must have been issued before the multiplier bits
	// can be trusted, since i_done is stale in the first ADD_SHIFT cycle.
	assign w_exit = (r_count != '0) && ((r_count >= LP_MAX_CNT) || i_done);

	always_ff @(posedge i_clk or negedge i_rst) begin : state_machine
		if (!i_rst) begin
			r_state <= IDLE;
		end else begin
			case (r_state)
				IDLE: begin
					if (w_accept)
						r_state <= INIT;
				end
				INIT: begin
					r_state <= ADD_SHIFT;
				end
				ADD_SHIFT: begin
					if (w_exit)
						r_state <= IDLE;
				end
				default: begin
					r_state <= IDLE;
				end
			endcase
		end
	end : state_machine

	// Every strobe is registered one cycle behind the state that sets it.
	always_ff @(posedge i_clk or negedge i_rst) begin : outputs
		if (!i_rst) begin
			r_ctrl  <= CTRL_RESET;
			r_ready <= 1'b0;
			r_count <= '0;
		end else begin
			case (r_state)
				IDLE: begin
					r_ctrl  <= CTRL_IDLE;
					r_ready <= !w_accept;
					r_count <= '0;
				end
				INIT: begin
					r_ctrl       <= CTRL_IDLE;
					r_ctrl.load  <= 1'b1;
					r_ctrl.clean <= 1'b1;
					r_ready      <= 1'b0;
					r_count      <= '0;
				end
				ADD_SHIFT: begin
					// The step issued from the exit cycle is the last one.
					r_ctrl       <= CTRL_IDLE;
					r_ctrl.step  <= !w_exit;
					r_ctrl.show  <= w_exit;
					r_ready      <= 1'b0;
					r_count      <= r_count + 1'b1;
				end
				default: begin
					r_ctrl  <= CTRL_IDLE;
					r_ready <= 1'b0;
					r_count <= '0;
				end
			endcase
		end
	end : outputs

	assign o_ctrl  = r_ctrl;
	assign o_ready = r_ready;

	// Operands must not be reloaded while a new start could be accepted.
	a_load_not_ready: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		!(r_ctrl.load && r_ready)
	);

	// The result capture is a single pulse per multiplication.
	a_show_single: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		r_ctrl.show |=> !r_ctrl.show
	);

endmodule

// ==== verilog/multiplier_shifter.sv ====
`timescale 1ns/1ps

module multiplier_shifter
	import mult_pkg::*;
#(
	parameter int P_WIDTH = DEFAULT_WIDTH
) (
	input  logic               i_clk,
	input  logic               i_rst,
	input  ctrl_t              i_ctrl,
	input  logic [P_WIDTH-1:0] i_multiplier,
	output logic               o_bit,
	output logic               o_done
);

	typedef logic [P_WIDTH-1:0] operand_t;

	operand_t r_mplr;
	operand_t w_mplr_next;

	// Each step exposes the next higher multiplier bit at position zero.
	assign w_mplr_next = r_mplr >> 1;

	// The register feeds the controller's exit test, so it is cleared
	// in reset to keep o_done defined before the first load.
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			r_mplr <= '0;
		end else if (i_ctrl.load) begin
			r_mplr <= i_multiplier;
		end else if (i_ctrl.step) begin
			r_mplr <= w_mplr_next;
		end
	end

	assign o_bit = r_mplr[0];

	// No bits left to add means the remaining steps are plain shifts.
	assign o_done = (r_mplr == '0);

	// Done must hold until the next load so the early exit is stable.
	a_done_sticky: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		(o_done && !i_ctrl.load) |=> o_done
	);

endmodule

// ==== verilog/partial_product_acc.sv ====
`timescale 1ns/1ps

module partial_product_acc
	import mult_pkg::*;
#(
	parameter int P_WIDTH = DEFAULT_WIDTH
) (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  ctrl_t                i_ctrl,
	input  logic                 i_bit,
	input  logic [P_WIDTH-1:0]   i_multiplicand,
	output logic [2*P_WIDTH-1:0] o_product
);

	localparam int P_SHW = $clog2(P_WIDTH + 1);

	typedef logic [P_WIDTH-1:0]   operand_t;
	typedef logic [2*P_WIDTH-1:0] product_t;
	typedef logic [P_WIDTH:0]     sum_t;
	typedef logic [P_SHW-1:0]     shift_t;

	localparam shift_t LP_FULL_SHIFTS = shift_t'(P_WIDTH);

	operand_t r_mcand;
	product_t r_acc;
	product_t r_result;
	shift_t   r_shifts;
	operand_t w_addend;
	sum_t     w_sum;
	product_t w_acc_next;
	shift_t   w_skip;

	assign w_addend = i_bit ? r_mcand : '0;

	// The upper half plus the multiplicand keeps its carry in the top bit.
	assign w_sum = {1'b0, r_acc[2*P_WIDTH-1:P_WIDTH]} + {1'b0, w_addend};

	// Carry and sum move down one place and the lowest bit drops out.
	assign w_acc_next = {w_sum, r_acc[P_WIDTH-1:1]};

	// Steps that an early exit skipped would only have shifted right.
	assign w_skip = LP_FULL_SHIFTS - r_shifts;

	// Clean is held high by the controller during reset, which clears
	// the partial product before the first operation.
	always_ff @(posedge i_clk) begin
		if (i_ctrl.load)
			r_mcand <= i_multiplicand;
		if (i_ctrl.clean)
			r_acc <= '0;
		else if (i_ctrl.step)
			r_acc <= w_acc_next;
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			r_shifts <= '0;
		end else if (i_ctrl.clean) begin
			r_shifts <= '0;
		end else if (i_ctrl.step) begin
			r_shifts <= r_shifts + 1'b1;
		end
	end

	// The aligned product is held here until the next show.
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			r_result <= '0;
		end else if (i_ctrl.show) begin
			r_result <= r_acc >> w_skip;
		end
	end

	assign o_product = r_result;

	// The visible product may only move right after a show strobe.
	a_result_on_show: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		!$stable(r_result) |-> $past(i_ctrl.show)
	);

endmodule

// ==== verilog/seq_multiplier.sv ====
`timescale 1ns/1ps

module seq_multiplier
	import mult_pkg::*;
#(
	parameter int P_WIDTH = DEFAULT_WIDTH
) (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_start,
	input  logic [P_WIDTH-1:0]   i_multiplicand,
	input  logic [P_WIDTH-1:0]   i_multiplier,
	output logic                 o_ready,
	output logic                 o_show,
	output logic [2*P_WIDTH-1:0] o_product
);

	// Strobes shared by the controller and both datapath halves.
	ctrl_t w_ctrl;

	// Current multiplier bit for the adder.
	logic w_bit;

	// Remaining multiplier bits are all zero.
	logic w_done;

	mult_control #(
		.P_WIDTH (P_WIDTH)
	) u_control (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (i_start),
		.i_done  (w_done),
		.o_ctrl  (w_ctrl),
		.o_ready (o_ready)
	);

	multiplier_shifter #(
		.P_WIDTH (P_WIDTH)
	) u_shifter (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_ctrl       (w_ctrl),
		.i_multiplier (i_multiplier),
		.o_bit        (w_bit),
		.o_done       (w_done)
	);

	partial_product_acc #(
		.P_WIDTH (P_WIDTH)
	) u_acc (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_ctrl         (w_ctrl),
		.i_bit          (w_bit),
		.i_multiplicand (i_multiplicand),
		.o_product      (o_product)
	);

	// The show strobe doubles as the completion pulse.
	assign o_show = w_ctrl.show;

endmodule

// ==== dv/tb_seq_multiplier.sv ====
`timescale 1ns/1ps

module tb_seq_multiplier
	import mult_pkg::*;
();

	localparam int P_WIDTH    = DEFAULT_WIDTH;
	localparam int LP_TIMEOUT = 4 * P_WIDTH;
	localparam int LP_RANDOM  = 200;

	typedef logic [P_WIDTH-1:0]   operand_t;
	typedef logic [2*P_WIDTH-1:0] product_t;

	logic     i_clk;
	logic     i_rst;
	logic     i_start;
	operand_t i_multiplicand;
	operand_t i_multiplier;
	logic     o_ready;
	logic     o_show;
	product_t o_product;

	integer seed;
	int     error_count;
	int     pass_count;
	int     fail_count;

	seq_multiplier #(
		.P_WIDTH (P_WIDTH)
	) u_dut (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_start        (i_start),
		.i_multiplicand (i_multiplicand),
		.i_multiplier   (i_multiplier),
		.o_ready        (o_ready),
		.o_show         (o_show),
		.o_product      (o_product)
	);

	always #4 i_clk = ~i_clk;

	// Full-width unsigned product, straight from the arithmetic definition.
	function automatic product_t ref_product(input operand_t a, input operand_t b);
		return product_t'(a) * product_t'(b);
	endfunction

	task automatic check_value(input string name, input product_t expected,
		input product_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_timeout(input string what);
		state_e st;
		st = u_dut.u_control.r_state;
		$display("ERROR: no %s within %0d cycles, controller state is %s",
			what, LP_TIMEOUT, st.name());
		error_count++;
	endtask

	task automatic wait_ready(output bit ok);
		int n;
		n = 0;
		@(negedge i_clk);
		while (!o_ready && n < LP_TIMEOUT) begin
			@(negedge i_clk);
			n++;
		end
		ok = o_ready;
		if (!ok)
			report_timeout("ready level");
	endtask

	// Counts falling edges from the start pulse up to the show pulse.
	task automatic wait_show(output bit ok, output int cycles);
		int n;
		n = 0;
		@(negedge i_clk);
		while (!o_show && n < LP_TIMEOUT) begin
			@(negedge i_clk);
			n++;
		end
		ok = o_show;
		cycles = n;
		if (!ok)
			report_timeout("show pulse");
	endtask

	task automatic pulse_start(input operand_t a, input operand_t b);
		@(posedge i_clk);
		i_multiplicand <= a;
		i_multiplier   <= b;
		i_start        <= 1'b1;
		@(posedge i_clk);
		i_start <= 1'b0;
	endtask

	task automatic run_mult(input string name, input operand_t a, input operand_t b,
		output int cycles);
		bit ok;
		cycles = 0;
		wait_ready(ok);
		if (!ok)
			return;
		pulse_start(a, b);
		wait_show(ok, cycles);
		if (!ok)
			return;
		// The result register loads on the edge that closes the show pulse.
		@(negedge i_clk);
		check_value(name, ref_product(a, b), o_product);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			pass_count++;
			$display("PASS %s", name);
		end else begin
			fail_count++;
			$display("FAIL %s (%0d errors)", name, error_count - errors_before);
		end
	endtask

	initial begin
		int          errors_before;
		int          cycles;
		int          top_cycles;
		int          low_cycles[3];
		int          extra_shows;
		bit          ok;
		bit          changed;
		logic [31:0] rnd;
		operand_t    a;
		operand_t    b;
		product_t    held;

		i_clk          = 1'b0;
		i_rst          = 1'b0;
		i_start        = 1'b0;
		i_multiplicand = '0;
		i_multiplier   = '0;
		seed           = 56772;
		error_count    = 0;
		pass_count     = 0;
		fail_count     = 0;

		repeat (16) @(posedge i_clk);
		i_rst <= 1'b1;

		errors_before = error_count;
		@(negedge i_clk);
		check_value("reset_state o_show", '0, product_t'(o_show));
		check_value("reset_state o_product", '0, o_product);
		wait_ready(ok);
		finish_test("reset_state", errors_before);

		// A zero multiplier still needs one step before the early exit.
		errors_before = error_count;
		run_mult("corner zero times value", '0, operand_t'(8'hA5), cycles);
		run_mult("corner value times zero", operand_t'(8'h5A), '0, cycles);
		run_mult("corner one times max", operand_t'(1), '1, cycles);
		run_mult("corner max times max", '1, '1, cycles);
		finish_test("corner_operands", errors_before);

		errors_before = error_count;
		run_mult("early multiplier 1", operand_t'(8'hC3), operand_t'(1), low_cycles[0]);
		run_mult("early multiplier 3", operand_t'(8'hC3), operand_t'(3), low_cycles[1]);
		run_mult("early multiplier 5", operand_t'(8'hC3), operand_t'(5), low_cycles[2]);
		run_mult("early multiplier top bit", operand_t'(8'hC3), operand_t'(8'h80), top_cycles);
		// Low multipliers run out of set bits well before the step count is full.
		foreach (low_cycles[i]) begin
			if (low_cycles[i] >= top_cycles) begin
				$display("CHECK FAILED early_termination mult %0d: expected < %0d, actual %0d",
					i, top_cycles, low_cycles[i]);
				error_count++;
			end
		end
		finish_test("early_termination", errors_before);

		errors_before = error_count;
		for (int i = 0; i < LP_RANDOM; i++) begin
			rnd = $random(seed);
			a   = rnd[P_WIDTH-1:0];
			rnd = $random(seed);
			b   = rnd[P_WIDTH-1:0];
			run_mult($sformatf("random pair %0d", i), a, b, cycles);
		end
		finish_test("random_operands", errors_before);

		// The second pulse lands after the operand load, during the steps.
		errors_before = error_count;
		a = operand_t'(8'h9D);
		b = operand_t'(8'hB7);
		wait_ready(ok);
		pulse_start(a, b);
		repeat (3) @(posedge i_clk);
		@(negedge i_clk);
		if (o_ready) begin
			$display("ERROR: ready is high while a multiplication should be running");
			error_count++;
		end
		pulse_start(operand_t'(8'h11), operand_t'(8'h22));
		wait_show(ok, cycles);
		if (ok) begin
			@(negedge i_clk);
			check_value("ignored_start product", ref_product(a, b), o_product);
			held        = o_product;
			extra_shows = 0;
			changed     = 1'b0;
			repeat (LP_TIMEOUT) begin
				@(negedge i_clk);
				if (o_show)
					extra_shows++;
				if (o_product !== held)
					changed = 1'b1;
			end
			check_value("ignored_start extra show pulses", '0, product_t'(extra_shows));
			if (changed) begin
				$display("ERROR: the product changed while the multiplier was idle");
				error_count++;
			end
		end
		run_mult("ignored_start next operation", operand_t'(8'h3C), operand_t'(8'h0F), cycles);
		finish_test("ignored_start", errors_before);

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
verilog/mult_pkg.sv
verilog/mult_control.sv
verilog/multiplier_shifter.sv
verilog/partial_product_acc.sv
verilog/seq_multiplier.sv
dv/tb_seq_multiplier.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the multiplier testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the log reports failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_seq_multiplier -f tb.f -o sim_tb > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulation exited with an error status" >> sim.log
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
